// ==== source/frame_table_pkg.sv ====
// ##########################################################################
// Frame table parser shared definitions
// Field geometry, buffer depths, credit limits and the payload types
// used by the ingress buffer, the field extractors and the result arbiter
// ##########################################################################

package frame_table_pkg;

    // One byte of the incoming frame stream
    typedef logic [7:0] byte_t;

    // Key field sits at the very start of the frame
    localparam int KEY_BYTES  = 16;
    localparam int KEY_OFFSET = 0;

    // Tag field follows directly behind the key
    localparam int TAG_BYTES  = 4;
    localparam int TAG_OFFSET = 16;

    // Byte [N-1] is the first byte of the field, so the field reads
    // most significant byte first
    typedef byte_t [KEY_BYTES-1:0] key_t;
    typedef byte_t [TAG_BYTES-1:0] tag_t;

    // Result bus is as wide as the largest field
    localparam int RESULT_W = $bits(key_t);

    // Ingress buffer geometry, also the sender's starting credit count
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // Byte position within a frame, saturating at the top value
    localparam int INDEX_W = 5;

    // Result credits held by the arbiter
    localparam int OUT_CREDITS_MAX = 4;
    localparam int CREDIT_W        = $clog2(OUT_CREDITS_MAX + 1);

    // Frame sequence number, wraps around
    typedef logic [7:0] frame_id_t;

    // Which field a result on the bus carries
    typedef enum logic {
        FIELD_KEY = 1'b0,
        FIELD_TAG = 1'b1
    } field_sel_t;

endpackage

// ==== source/ingress_credit_fifo.sv ====
// ##########################################################################
// Ingress byte buffer with credit return
// Circular buffer that accepts every beat, pops while not stalled, returns
// one credit per pop and tracks byte position and frame number
// ##########################################################################

`timescale 1ns/100ps

module ingress_credit_fifo
    import frame_table_pkg::*;
(
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  byte_t                in_data,
    input  logic                 in_last,
    output logic                 in_credit,
    input  logic                 pop_stall,
    output logic                 pop_valid,
    output byte_t                pop_data,
    output logic                 pop_last,
    output logic [INDEX_W-1:0]   pop_index,
    output frame_id_t            pop_frame_id
);

    // Storage holds the byte and its end of frame flag side by side
    byte_t                  data_mem [FIFO_DEPTH];
    logic                   last_mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0]  wr_ptr;
    logic [FIFO_PTR_W-1:0]  rd_ptr;
    logic [FIFO_CNT_W-1:0]  count;

    // The sender spends a credit per beat, so there is always room
    assign pop_valid = (count != '0) && !pop_stall;
    assign pop_data  = data_mem[rd_ptr];
    assign pop_last  = last_mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (in_valid) begin
            data_mem[wr_ptr] <= in_data;
            last_mem[wr_ptr] <= in_last;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            in_credit    <= 1'b0;
            pop_index    <= '0;
            pop_frame_id <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_valid) begin
                rd_ptr <= (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count     <= count + FIFO_CNT_W'(in_valid) - FIFO_CNT_W'(pop_valid);
            in_credit <= pop_valid;

            // Position restarts and the frame number advances after a last byte
            if (pop_valid) begin
                if (pop_last) begin
                    pop_index    <= '0;
                    pop_frame_id <= pop_frame_id + 1'b1;
                end else if (pop_index != '1) begin
                    pop_index <= pop_index + 1'b1;
                end
            end
        end
    end

endmodule

// ==== source/field_extractor.sv ====
// ##########################################################################
// Fixed offset field extractor
// Captures one field per frame from the popped byte stream and holds it,
// with its frame number, until the result arbiter grants it
// ##########################################################################

`timescale 1ns/100ps

module field_extractor
    import frame_table_pkg::*;
#(
    parameter type field_t = key_t,
    parameter int  OFFSET  = KEY_OFFSET
) (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 pop_valid,
    input  byte_t                pop_data,
    input  logic                 pop_last,
    input  logic [INDEX_W-1:0]   pop_index,
    input  frame_id_t            pop_frame_id,
    output logic                 hold,
    output field_t               field_value,
    output frame_id_t            field_frame_id,
    input  logic                 grant
);

    localparam int FIELD_W     = $bits(field_t);
    localparam int FIELD_BYTES = FIELD_W / 8;
    localparam int LAST_POS    = OFFSET + FIELD_BYTES - 1;

    logic [FIELD_W-1:0] capture;
    logic [FIELD_W-1:0] capture_next;
    logic               done;
    logic               complete;

    // Build the next capture value, starting clean on the first byte of a frame
    always_comb begin
        int pos;
        pos          = int'(pop_index) - OFFSET;
        capture_next = (pop_index == '0) ? '0 : capture;
        if ((pos >= 0) && (pos < FIELD_BYTES)) begin
            capture_next[(FIELD_BYTES - 1 - pos) * 8 +: 8] = pop_data;
        end
    end

    // The field is finished by its final byte or by an early end of frame
    assign complete = pop_valid && !done
                      && ((int'(pop_index) == LAST_POS) || pop_last);

    always_ff @(posedge clock) begin
        if (pop_valid) begin
            capture <= capture_next;
        end
        if (complete) begin
            field_value    <= field_t'(capture_next);
            field_frame_id <= pop_frame_id;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
            hold <= 1'b0;
        end else begin
            // Only one result per frame, rearmed when the frame ends
            if (pop_valid) begin
                if (pop_last) begin
                    done <= 1'b0;
                end else if (complete) begin
                    done <= 1'b1;
                end
            end

            // Popping is stalled while holding, so completion and grant never meet
            if (complete) begin
                hold <= 1'b1;
            end else if (grant) begin
                hold <= 1'b0;
            end
        end
    end

endmodule

// ==== source/result_arbiter.sv ====
// ##########################################################################
// Result arbiter
// Shares the credit controlled result bus between the key and tag
// extractors, round-robin, one grant per cycle
// ##########################################################################

`timescale 1ns/100ps

module result_arbiter
    import frame_table_pkg::*;
(
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  key_hold,
    input  key_t                  key_value,
    input  frame_id_t             key_frame_id,
    input  logic                  tag_hold,
    input  tag_t                  tag_value,
    input  frame_id_t             tag_frame_id,
    output logic                  key_grant,
    output logic                  tag_grant,
    input  logic                  out_credit,
    output logic                  out_valid,
    output field_sel_t            out_sel,
    output frame_id_t             out_frame_id,
    output logic [RESULT_W-1:0]   out_data
);

    logic [CREDIT_W-1:0] credits;
    logic [CREDIT_W-1:0] credits_sum;
    field_sel_t          last_winner;
    logic                key_elig;
    logic                tag_elig;
    logic                pick_key;
    logic                pick_tag;

    // A holder granted last cycle is dropping its hold right now
    assign key_elig = key_hold && !key_grant && (credits != '0);
    assign tag_elig = tag_hold && !tag_grant && (credits != '0);

    // When both want the bus, the one that lost last time goes first
    assign pick_key = key_elig && (!tag_elig || (last_winner == FIELD_TAG));
    assign pick_tag = tag_elig && !pick_key;

    // A credit is spent as soon as the grant is issued
    assign credits_sum = credits + CREDIT_W'(out_credit) - CREDIT_W'(pick_key || pick_tag);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            credits     <= '0;
            last_winner <= FIELD_TAG;
            key_grant   <= 1'b0;
            tag_grant   <= 1'b0;
            out_valid   <= 1'b0;
        end else begin
            credits   <= (credits_sum > CREDIT_W'(OUT_CREDITS_MAX))
                         ? CREDIT_W'(OUT_CREDITS_MAX) : credits_sum;
            key_grant <= pick_key;
            tag_grant <= pick_tag;
            if (pick_key) begin
                last_winner <= FIELD_KEY;
            end else if (pick_tag) begin
                last_winner <= FIELD_TAG;
            end
            out_valid <= key_grant || tag_grant;
        end
    end

    // Field values stay put while held, so they are taken in the grant cycle
    always_ff @(posedge clock) begin
        if (tag_grant) begin
            out_sel      <= FIELD_TAG;
            out_frame_id <= tag_frame_id;
            out_data     <= {{(RESULT_W - $bits(tag_t)){1'b0}}, tag_value};
        end else if (key_grant) begin
            out_sel      <= FIELD_KEY;
            out_frame_id <= key_frame_id;
            out_data     <= key_value;
        end
    end

endmodule

// ==== source/frame_table_parser_top.sv ====
// ##########################################################################
// Frame table parser top level
// Ingress buffer feeding key and tag extractors, with their results
// merged onto one credit controlled result bus
// ##########################################################################

`timescale 1ns/100ps

module frame_table_parser_top
    import frame_table_pkg::*;
(
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  byte_t                 in_data,
    input  logic                  in_last,
    output logic                  in_credit,
    input  logic                  out_credit,
    output logic                  out_valid,
    output field_sel_t            out_sel,
    output frame_id_t             out_frame_id,
    output logic [RESULT_W-1:0]   out_data
);

    logic               pop_stall;
    logic               pop_valid;
    byte_t              pop_data;
    logic               pop_last;
    logic [INDEX_W-1:0] pop_index;
    frame_id_t          pop_frame_id;

    logic               key_hold;
    key_t               key_value;
    frame_id_t          key_frame_id;
    logic               key_grant;
    logic               tag_hold;
    tag_t               tag_value;
    frame_id_t          tag_frame_id;
    logic               tag_grant;

    // Either pending result freezes the shared byte stream
    assign pop_stall = key_hold | tag_hold;

    ingress_credit_fifo ingress_fifo (
        .clock        (clock),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .in_last      (in_last),
        .in_credit    (in_credit),
        .pop_stall    (pop_stall),
        .pop_valid    (pop_valid),
        .pop_data     (pop_data),
        .pop_last     (pop_last),
        .pop_index    (pop_index),
        .pop_frame_id (pop_frame_id)
    );

    field_extractor #(.field_t(key_t), .OFFSET(KEY_OFFSET)) key_extractor (
        .clock          (clock),
        .rst_n          (rst_n),
        .pop_valid      (pop_valid),
        .pop_data       (pop_data),
        .pop_last       (pop_last),
        .pop_index      (pop_index),
        .pop_frame_id   (pop_frame_id),
        .hold           (key_hold),
        .field_value    (key_value),
        .field_frame_id (key_frame_id),
        .grant          (key_grant)
    );

    field_extractor #(.field_t(tag_t), .OFFSET(TAG_OFFSET)) tag_extractor (
        .clock          (clock),
        .rst_n          (rst_n),
        .pop_valid      (pop_valid),
        .pop_data       (pop_data),
        .pop_last       (pop_last),
        .pop_index      (pop_index),
        .pop_frame_id   (pop_frame_id),
        .hold           (tag_hold),
        .field_value    (tag_value),
        .field_frame_id (tag_frame_id),
        .grant          (tag_grant)
    );

    result_arbiter arbiter (
        .clock        (clock),
        .rst_n        (rst_n),
        .key_hold     (key_hold),
        .key_value    (key_value),
        .key_frame_id (key_frame_id),
        .tag_hold     (tag_hold),
        .tag_value    (tag_value),
        .tag_frame_id (tag_frame_id),
        .key_grant    (key_grant),
        .tag_grant    (tag_grant),
        .out_credit   (out_credit),
        .out_valid    (out_valid),
        .out_sel      (out_sel),
        .out_frame_id (out_frame_id),
        .out_data     (out_data)
    );

endmodule

// ==== tests/tb_clock_gen.sv ====
// ##########################################################################
// Testbench clock and reset generator
// 4 ns clock, reset held low for the first 8 cycles
// ##########################################################################

`timescale 1ns/100ps

module tb_clock_gen (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Release lands just after an edge so it never races the flops
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clock);
        #1;
        rst_n = 1'b1;
    end

endmodule

// ==== tests/tb_frame_table_parser.sv ====
// ##########################################################################
// Frame table parser testbench
// Sends a table of frames under ingress credit control, returns result
// credits after random or withheld delays and checks every result
// ##########################################################################

`timescale 1ns/100ps

module tb_frame_table_parser
    import frame_table_pkg::*;
();

    localparam int ROWS    = 8;
    localparam int MAX_LEN = 40;
    localparam int TIMEOUT = 1000;
    localparam int PAUSE   = 60;
    localparam int WINDOW  = 2;
    localparam int FRAME_LEN [ROWS] = '{1, 15, 16, 17, 19, 20, 21, 40};
    localparam bit WITHHOLD [ROWS]  = '{0, 0, 1, 0, 0, 1, 0, 0};

    logic                clock;
    logic                rst_n;
    logic                in_valid;
    byte_t               in_data;
    logic                in_last;
    logic                in_credit;
    logic                out_credit;
    logic                out_valid;
    field_sel_t          out_sel;
    frame_id_t           out_frame_id;
    logic [RESULT_W-1:0] out_data;

    int                  seed = 32'hf7247486;
    byte_t               frame_bytes [ROWS][MAX_LEN];
    logic [RESULT_W-1:0] exp_key [ROWS];
    logic [RESULT_W-1:0] exp_tag [ROWS];
    bit                  seen_key [ROWS];
    bit                  seen_tag [ROWS];
    int                  bytes_sent = 0;
    int                  credits_returned = 0;
    int                  credits_given = 0;
    int                  results_seen = 0;
    int                  last_id = 0;
    int                  main_errors = 0;
    int                  mon_errors = 0;

    tb_clock_gen clock_gen (
        .clock (clock),
        .rst_n (rst_n)
    );

    frame_table_parser_top dut0 (
        .clock        (clock),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .in_last      (in_last),
        .in_credit    (in_credit),
        .out_credit   (out_credit),
        .out_valid    (out_valid),
        .out_sel      (out_sel),
        .out_frame_id (out_frame_id),
        .out_data     (out_data)
    );

    task automatic step();
        @(posedge clock);
        #1;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s", what);
        $display("Errors: %0d", main_errors + mon_errors);
        $display(">>> FAIL");
        $finish;
    endtask

    // Bytes past the end of a frame stay zero, which is how a short field reads
    task automatic build_table();
        int r;
        int p;
        for (r = 0; r < ROWS; r++) begin
            exp_key[r] = '0;
            exp_tag[r] = '0;
            for (p = 0; p < MAX_LEN; p++) begin
                frame_bytes[r][p] = (p < FRAME_LEN[r]) ? byte_t'($random(seed)) : 8'h00;
            end
            // Field bytes shift in from the bottom, so the first one ends up on top
            for (p = 0; p < KEY_BYTES; p++) begin
                exp_key[r] = {exp_key[r][RESULT_W-9:0], frame_bytes[r][KEY_OFFSET + p]};
            end
            for (p = 0; p < TAG_BYTES; p++) begin
                exp_tag[r] = {exp_tag[r][RESULT_W-9:0], frame_bytes[r][TAG_OFFSET + p]};
            end
        end
    endtask

    task automatic send_frames();
        int r;
        int i;
        int cycles;
        for (r = 0; r < ROWS; r++) begin
            for (i = 0; i < FRAME_LEN[r]; i++) begin
                cycles = 0;
                while ((FIFO_DEPTH + credits_returned - bytes_sent <= 0) && (cycles < TIMEOUT)) begin
                    in_valid = 1'b0;
                    step();
                    cycles++;
                end
                if (cycles >= TIMEOUT) begin
                    report_timeout("sender never got an ingress credit back");
                end
                in_valid = 1'b1;
                in_data  = frame_bytes[r][i];
                in_last  = (i == FRAME_LEN[r] - 1);
                bytes_sent++;
                step();
            end
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    // Each result needs its own credit; flagged frames get their key credit late
    task automatic return_credits();
        int r;
        int delay;
        int cycles;
        for (r = 0; r < 2 * ROWS; r++) begin
            if (WITHHOLD[r / 2] && (r % 2 == 0)) begin
                delay = PAUSE;
            end else begin
                delay = $unsigned($random(seed)) % 4;
            end
            repeat (delay) step();
            cycles = 0;
            while ((credits_given - results_seen >= WINDOW) && (cycles < TIMEOUT)) begin
                step();
                cycles++;
            end
            if (cycles >= TIMEOUT) begin
                report_timeout("results stopped arriving while credits were outstanding");
            end
            out_credit = 1'b1;
            credits_given++;
            step();
            out_credit = 1'b0;
        end
    endtask

    task automatic check_result();
        int id;
        id = int'(out_frame_id);
        if (results_seen >= credits_given) begin
            $display("Result for frame %0d arrived without a returned credit", id);
            mon_errors++;
        end
        results_seen++;
        if (id < last_id) begin
            $display("Frame %0d result came after frame %0d", id, last_id);
            mon_errors++;
        end
        last_id = id;
        if (id >= ROWS) begin
            $display("Result carries unknown frame number %0d", id);
            mon_errors++;
        end else if (out_sel == FIELD_KEY) begin
            if (seen_key[id]) begin
                $display("Frame %0d gave a second key result", id);
                mon_errors++;
            end
            seen_key[id] = 1'b1;
            if (out_data !== exp_key[id]) begin
                $display("[ERROR] out_data key frame %0d: got %h, expected %h",
                         id, out_data, exp_key[id]);
                mon_errors++;
            end
        end else begin
            if (seen_tag[id]) begin
                $display("Frame %0d gave a second tag result", id);
                mon_errors++;
            end
            seen_tag[id] = 1'b1;
            if (out_data !== exp_tag[id]) begin
                $display("[ERROR] out_data tag frame %0d: got %h, expected %h",
                         id, out_data, exp_tag[id]);
                mon_errors++;
            end
        end
    endtask

    // Registered outputs are sampled mid cycle
    always @(negedge clock) begin
        if (rst_n) begin
            if (in_credit) begin
                credits_returned++;
                // A credit for a byte never sent lifts the sender above its start count
                if (credits_returned > bytes_sent) begin
                    $display("Ingress credit came back for a byte that was never sent");
                    mon_errors++;
                end
            end
            if (out_valid) begin
                check_result();
            end
        end
    end

    initial begin : main
        int cycles;
        int r;
        in_valid   = 1'b0;
        in_data    = '0;
        in_last    = 1'b0;
        out_credit = 1'b0;
        build_table();
        cycles = 0;
        while ((rst_n !== 1'b1) && (cycles < TIMEOUT)) begin
            @(negedge clock);
            cycles++;
        end
        if (cycles >= TIMEOUT) begin
            report_timeout("reset was never released");
        end
        if ((in_credit !== 1'b0) || (out_valid !== 1'b0)) begin
            $display("[ERROR] in_credit/out_valid after reset: got %h/%h, expected 0/0",
                     in_credit, out_valid);
            main_errors++;
        end
        step();
        fork
            send_frames();
            return_credits();
        join
        cycles = 0;
        while (((results_seen < 2 * ROWS) || (credits_returned < bytes_sent))
               && (cycles < TIMEOUT)) begin
            step();
            cycles++;
        end
        if (cycles >= TIMEOUT) begin
            report_timeout("not all results or ingress credits arrived");
        end
        if (credits_returned != bytes_sent) begin
            $display("[ERROR] in_credit pulses: got %h, expected %h", credits_returned, bytes_sent);
            main_errors++;
        end
        for (r = 0; r < ROWS; r++) begin
            if (!seen_key[r] || !seen_tag[r]) begin
                $display("Frame %0d is missing its key or tag result", r);
                main_errors++;
            end
        end
        $display("Errors: %0d (sequence %0d, results %0d)",
                 main_errors + mon_errors, main_errors, mon_errors);
        if (main_errors + mon_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
source/frame_table_pkg.sv
source/ingress_credit_fifo.sv
source/field_extractor.sv
source/result_arbiter.sv
source/frame_table_parser_top.sv
tests/tb_clock_gen.sv
tests/tb_frame_table_parser.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_frame_table_parser
FILELIST = filelist.f
OBJ_DIR  = obj_dir

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
